/* filelist.f */
verilog/depth_pkg.sv
verilog/request_fifo.sv
verilog/fragment_dispatch.sv
verilog/depth_fetch.sv
verilog/depth_lane.sv
verilog/memory_arbiter.sv
verilog/depth_test_unit.sv
sim/framebuffer_model.sv
sim/depth_test_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the depth-test testbench with Verilator, then judge the run from its log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module depth_test_tb \
    -f filelist.f > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/Vdepth_test_tb > sim.log 2>&1
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && exit 1
grep -q "Simulation finished: PASS" sim.log || exit 1
exit 0

/* sim/depth_test_tb.sv */
`timescale 1ns/1ps

module depth_test_tb;

    localparam int lane_count = 4;
    localparam int lane_depth = 4;
    localparam int pixel_count = 512;
    localparam int stream_length = 64;
    localparam int repeat_length = 24;
    localparam int fragment_total = 3 + 2 * stream_length + repeat_length;
    localparam int watchdog_cycles = fragment_total * 200;

    logic clock;
    logic reset;
    logic fragment_valid;
    logic fragment_stall;
    logic waitrequest;
    logic readdatavalid;
    logic slow;
    logic [31:0] readdata;
    logic [31:0] passed_count;
    logic [31:0] failed_count;
    depth_pkg::fragment_t fragment;
    depth_pkg::bus_t bus;

    // Expected framebuffer state for each pixel that was ever written
    logic [31:0] ref_depth [int];
    logic [23:0] ref_color [int];
    int exp_pass;
    int exp_fail;
    int checks;
    int errors;
    integer seed = 32'h228d;

    depth_test_unit #(.lane_count(lane_count), .lane_depth(lane_depth)) i_dut (
        .clock(clock),
        .reset(reset),
        .fragment_valid(fragment_valid),
        .fragment(fragment),
        .fragment_stall(fragment_stall),
        .bus(bus),
        .waitrequest(waitrequest),
        .readdata(readdata),
        .readdatavalid(readdatavalid),
        .passed_count(passed_count),
        .failed_count(failed_count)
    );

    framebuffer_model #(.word_count(2 * pixel_count)) i_mem (
        .clock(clock),
        .reset(reset),
        .slow(slow),
        .bus(bus),
        .waitrequest(waitrequest),
        .readdata(readdata),
        .readdatavalid(readdatavalid)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    initial begin
        #(watchdog_cycles * 100);
        $display("Timeout: the counters did not reach their totals within %0d cycles",
                 watchdog_cycles);
        $display("Checks: %0d, errors: %0d", checks, errors + 1);
        $display("Simulation finished: FAIL");
        $finish;
    end

    function automatic logic [31:0] initial_word(int index);
        return (index * 32'h2545_f491) ^ 32'h6c07_8965;
    endfunction

    function automatic logic [31:0] stored_depth(int pixel);
        return ref_depth.exists(pixel) ? ref_depth[pixel] : initial_word(2 * pixel + 1);
    endfunction

    function automatic depth_pkg::fragment_t make_fragment(int pixel, logic [31:0] depth,
                                                           logic [23:0] color);
        depth_pkg::fragment_t f;
        f.addr = depth_pkg::addr_width'(pixel * 8);
        f.color = color;
        f.depth = depth;
        return f;
    endfunction

    // Only a strictly smaller depth replaces what the pixel holds
    function automatic void apply_reference(depth_pkg::fragment_t f);
        int pixel;
        pixel = int'(f.addr) / 8;
        if (f.depth < stored_depth(pixel)) begin
            ref_depth[pixel] = f.depth;
            ref_color[pixel] = f.color;
            exp_pass++;
        end else begin
            exp_fail++;
        end
    endfunction

    task automatic check_value(string test, string what, logic [31:0] expected,
                               logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("mismatch %s %s expected %h actual %h", test, what, expected, actual);
        end
    endtask

    task automatic check_memory(string test);
        logic [31:0] color_word;
        for (int p = 0; p < pixel_count; p++) begin
            color_word = initial_word(2 * p);
            if (ref_color.exists(p))
                color_word[23:0] = ref_color[p];
            check_value(test, $sformatf("pixel %0d colour", p), color_word, i_mem.mem[2 * p]);
            check_value(test, $sformatf("pixel %0d depth", p), stored_depth(p),
                        i_mem.mem[2 * p + 1]);
        end
    endtask

    task automatic check_counts(string test);
        check_value(test, "passed_count", exp_pass, passed_count);
        check_value(test, "failed_count", exp_fail, failed_count);
    endtask

    task automatic check_bus_idle(string test);
        checks++;
        assert (!bus.read && !bus.write) else begin
            errors++;
            $display("%s: a bus read or write appeared before the unit was ready", test);
        end
    endtask

    // Called just after a rising edge and holds the fragment until the unit takes it
    task automatic send_fragment(depth_pkg::fragment_t f);
        logic taken;
        fragment_valid = 1'b1;
        fragment = f;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clock);
            taken = !fragment_stall;
            @(posedge clock);
            #1;
        end
        fragment_valid = 1'b0;
        apply_reference(f);
    endtask

    // Every accepted fragment retires exactly once as either a pass or a fail
    task automatic wait_for_counts();
        while (passed_count + failed_count < 32'(exp_pass + exp_fail))
            @(negedge clock);
        @(posedge clock);
        #1;
    endtask

    task automatic reset_test();
        #1 reset = 1'b0;
        repeat (3) begin
            @(negedge clock);
            check_bus_idle("reset");
            checks++;
            assert (fragment_stall) else begin
                errors++;
                $display("reset: fragment_stall was low while reset was held");
            end
            @(posedge clock);
        end
        #1 reset = 1'b1;
        do begin
            @(negedge clock);
            check_bus_idle("reset");
        end while (fragment_stall);
        @(posedge clock);
        #1;
        check_memory("reset");
    endtask

    task automatic single_pass_test();
        send_fragment(make_fragment(5, stored_depth(5) >> 1, 24'($random(seed))));
        wait_for_counts();
        check_value("single_pass", "passed_count", 1, passed_count);
        check_counts("single_pass");
        check_memory("single_pass");
    endtask

    task automatic reject_test();
        send_fragment(make_fragment(6, stored_depth(6), 24'($random(seed))));
        send_fragment(make_fragment(7, 32'hffff_ffff, 24'($random(seed))));
        wait_for_counts();
        check_counts("reject");
        check_memory("reject");
    endtask

    task automatic stream_test(string test, int first_pixel);
        for (int i = 0; i < stream_length; i++)
            send_fragment(make_fragment(first_pixel + i, $random(seed), 24'($random(seed))));
        wait_for_counts();
        check_counts(test);
        check_memory(test);
    endtask

    // Pairs of fragments hit the same pixel back to back
    task automatic same_pixel_test();
        for (int i = 0; i < repeat_length; i++)
            send_fragment(make_fragment(100 + (i / 2) % 4, $random(seed),
                                        24'($random(seed))));
        wait_for_counts();
        check_counts("same_pixel");
        check_memory("same_pixel");
    endtask

    initial begin
        reset = 1'b1;
        fragment_valid = 1'b0;
        fragment = '0;
        slow = 1'b0;
        checks = 0;
        errors = 0;
        exp_pass = 0;
        exp_fail = 0;
        reset_test();
        single_pass_test();
        reject_test();
        stream_test("stream", 16);
        same_pixel_test();
        slow = 1'b1;
        stream_test("slow_bus", 200);
        slow = 1'b0;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* sim/framebuffer_model.sv */
`timescale 1ns/1ps

module framebuffer_model #(
    parameter int word_count = 1024
) (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             slow,
    input  depth_pkg::bus_t                  bus,
    output logic                             waitrequest,
    output logic [depth_pkg::data_width-1:0] readdata,
    output logic                             readdatavalid
);

    localparam int index_bits = $clog2(word_count);

    logic [31:0] mem [word_count];
    logic [31:0] data_q [$];
    int unsigned due_q [$];
    int unsigned cycle;
    int unsigned last_due;
    int unsigned due;
    logic [index_bits-1:0] index;
    integer seed = 32'h228d;

    // Every word starts from a hash of its own address
    initial begin
        for (int i = 0; i < word_count; i++)
            mem[i] = (i * 32'h2545_f491) ^ 32'h6c07_8965;
        waitrequest = 1'b0;
        readdatavalid = 1'b0;
        readdata = '0;
        cycle = 0;
        last_due = 0;
    end

    // The bus is stable at the falling edge and waitrequest only moves after the rising one
    always @(negedge clock) begin
        if (reset && !waitrequest && (bus.read || bus.write)) begin
            index = bus.address[index_bits+1:2];
            if (bus.write) begin
                for (int b = 0; b < 4; b++) begin
                    if (bus.byteenable[b])
                        mem[index][8*b +: 8] = bus.writedata[8*b +: 8];
                end
            end else begin
                if (slow)
                    due = cycle + 8 + ($unsigned($random(seed)) % 24);
                else
                    due = cycle + 1 + ($unsigned($random(seed)) % 4);
                // Data comes back in request order, one word per cycle
                if (due <= last_due)
                    due = last_due + 1;
                last_due = due;
                data_q.push_back(mem[index]);
                due_q.push_back(due);
            end
        end
    end

    always @(posedge clock) begin
        #1;
        cycle = cycle + 1;
        waitrequest = ($unsigned($random(seed)) % 100) < (slow ? 80 : 25);
        if (due_q.size() != 0 && due_q[0] <= cycle) begin
            readdata = data_q.pop_front();
            void'(due_q.pop_front());
            readdatavalid = 1'b1;
        end else begin
            readdatavalid = 1'b0;
        end
    end

endmodule

/* verilog/depth_test_unit.sv */
`timescale 1ns/1ps

module depth_test_unit #(
    parameter int lane_count = 4,
    parameter int lane_depth = 4
) (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             fragment_valid,
    input  depth_pkg::fragment_t             fragment,
    output logic                             fragment_stall,
    output depth_pkg::bus_t                  bus,
    input  logic                             waitrequest,
    input  logic [depth_pkg::data_width-1:0] readdata,
    input  logic                             readdatavalid,
    output logic [31:0]                      passed_count,
    output logic [31:0]                      failed_count
);

    logic [lane_count-1:0] frag_valid;
    logic [lane_count-1:0] lane_stall;
    logic [lane_count-1:0] rd_valid;
    logic [lane_count-1:0] rd_grant;
    logic [lane_count-1:0] wr_valid;
    logic [lane_count-1:0] wr_grant;
    logic [lane_count-1:0] rd_return_valid;
    logic [lane_count-1:0] retire_pass;
    logic [lane_count-1:0] retire_fail;
    depth_pkg::read_req_t [lane_count-1:0] rd_req;
    depth_pkg::write_req_t [lane_count-1:0] wr_req;
    depth_pkg::fragment_t frag;
    logic [depth_pkg::data_width-1:0] rd_return_data;

    fragment_dispatch #(.lane_count(lane_count)) i_dispatch (
        .clock(clock),
        .reset(reset),
        .fragment_valid(fragment_valid),
        .fragment(fragment),
        .fragment_stall(fragment_stall),
        .lane_valid(frag_valid),
        .lane_fragment(frag),
        .lane_stall(lane_stall)
    );

    for (genvar i = 0; i < lane_count; i++) begin : g_lane
        depth_lane #(.lane_depth(lane_depth)) i_lane (
            .clock(clock),
            .reset(reset),
            .frag_valid(frag_valid[i]),
            .frag(frag),
            .stall(lane_stall[i]),
            .rd_valid(rd_valid[i]),
            .rd_req(rd_req[i]),
            .rd_grant(rd_grant[i]),
            .rd_return_valid(rd_return_valid[i]),
            .rd_return_data(rd_return_data),
            .wr_valid(wr_valid[i]),
            .wr_req(wr_req[i]),
            .wr_grant(wr_grant[i]),
            .retire_pass(retire_pass[i]),
            .retire_fail(retire_fail[i])
        );
    end

    memory_arbiter #(.lane_count(lane_count)) i_arbiter (
        .clock(clock),
        .reset(reset),
        .rd_valid(rd_valid),
        .rd_req(rd_req),
        .rd_grant(rd_grant),
        .wr_valid(wr_valid),
        .wr_req(wr_req),
        .wr_grant(wr_grant),
        .rd_return_valid(rd_return_valid),
        .rd_return_data(rd_return_data),
        .retire_pass(retire_pass),
        .retire_fail(retire_fail),
        .bus(bus),
        .waitrequest(waitrequest),
        .readdata(readdata),
        .readdatavalid(readdatavalid),
        .passed_count(passed_count),
        .failed_count(failed_count)
    );

endmodule

/* verilog/memory_arbiter.sv */
`timescale 1ns/1ps

module memory_arbiter #(
    parameter int lane_count = 4
) (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic [lane_count-1:0]                  rd_valid,
    input  depth_pkg::read_req_t [lane_count-1:0]  rd_req,
    output logic [lane_count-1:0]                  rd_grant,
    input  logic [lane_count-1:0]                  wr_valid,
    input  depth_pkg::write_req_t [lane_count-1:0] wr_req,
    output logic [lane_count-1:0]                  wr_grant,
    output logic [lane_count-1:0]                  rd_return_valid,
    output logic [depth_pkg::data_width-1:0]       rd_return_data,
    input  logic [lane_count-1:0]                  retire_pass,
    input  logic [lane_count-1:0]                  retire_fail,
    output depth_pkg::bus_t                        bus,
    input  logic                                   waitrequest,
    input  logic [depth_pkg::data_width-1:0]       readdata,
    input  logic                                   readdatavalid,
    output logic [31:0]                            passed_count,
    output logic [31:0]                            failed_count
);

    localparam int lane_bits = $clog2(lane_count);
    localparam int tag_depth = 2 * lane_count;
    typedef logic [lane_bits-1:0] lane_idx_t;

    lane_idx_t wr_ptr;
    lane_idx_t rd_ptr;
    lane_idx_t wr_sel;
    lane_idx_t rd_sel;
    lane_idx_t cur_lane;
    lane_idx_t locked_lane;
    lane_idx_t tag_head;
    logic wr_any;
    logic rd_any;
    logic cur_write;
    logic cur_read;
    logic locked;
    logic locked_write;
    logic tag_full;
    logic tag_empty;
    logic accepted;

    // Scan downwards so the lane nearest the pointer wins
    always_comb begin
        wr_any = 1'b0;
        rd_any = 1'b0;
        wr_sel = wr_ptr;
        rd_sel = rd_ptr;
        for (int k = lane_count - 1; k >= 0; k--) begin
            if (wr_valid[wr_ptr + lane_idx_t'(k)]) begin
                wr_any = 1'b1;
                wr_sel = wr_ptr + lane_idx_t'(k);
            end
            if (rd_valid[rd_ptr + lane_idx_t'(k)]) begin
                rd_any = 1'b1;
                rd_sel = rd_ptr + lane_idx_t'(k);
            end
        end
    end

    // A request stalled by waitrequest stays on the bus until accepted
    always_comb begin
        if (locked) begin
            cur_write = locked_write;
            cur_read = !locked_write;
            cur_lane = locked_lane;
        end else begin
            cur_write = wr_any;
            cur_read = !wr_any && rd_any && !tag_full;
            cur_lane = wr_any ? wr_sel : rd_sel;
        end
    end

    always_comb begin
        bus.read = cur_read;
        bus.write = cur_write;
        bus.address = cur_write ? wr_req[cur_lane].addr : rd_req[cur_lane].addr;
        bus.byteenable = cur_write ? wr_req[cur_lane].byteenable : 4'b1111;
        bus.writedata = cur_write ? wr_req[cur_lane].data : '0;
    end

    assign accepted = (cur_read || cur_write) && !waitrequest;

    always_comb begin
        rd_grant = '0;
        wr_grant = '0;
        rd_grant[cur_lane] = accepted && cur_read;
        wr_grant[cur_lane] = accepted && cur_write;
    end

    request_fifo #(.payload_t(lane_idx_t), .depth(tag_depth)) i_tag_fifo (
        .clock(clock),
        .reset(reset),
        .push(accepted && cur_read),
        .push_data(cur_lane),
        .pop(readdatavalid),
        .pop_data(tag_head),
        .full(tag_full),
        .empty(tag_empty)
    );

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            locked <= 1'b0;
            locked_write <= 1'b0;
            locked_lane <= '0;
            rd_return_valid <= '0;
            passed_count <= '0;
            failed_count <= '0;
        end else begin
            if (accepted && cur_write)
                wr_ptr <= cur_lane + 1'b1;
            if (accepted && cur_read)
                rd_ptr <= cur_lane + 1'b1;
            locked <= (cur_read || cur_write) && waitrequest;
            locked_write <= cur_write;
            locked_lane <= cur_lane;
            rd_return_valid <= readdatavalid ? (lane_count'(1) << tag_head) : '0;
            passed_count <= passed_count + 32'($countones(retire_pass));
            failed_count <= failed_count + 32'($countones(retire_fail));
        end
    end

    always_ff @(posedge clock) begin
        if (readdatavalid)
            rd_return_data <= readdata;
    end

    assert property (@(posedge clock) disable iff (!reset) readdatavalid |-> !tag_empty);

    // Lanes must keep a stalled request raised until it is granted
    assert property (@(posedge clock) disable iff (!reset)
        locked |-> (locked_write ? wr_valid[locked_lane] : rd_valid[locked_lane]));

endmodule

/* verilog/depth_lane.sv */
`timescale 1ns/1ps

module depth_lane #(
    parameter int lane_depth = 4
) (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             frag_valid,
    input  depth_pkg::fragment_t             frag,
    output logic                             stall,
    output logic                             rd_valid,
    output depth_pkg::read_req_t             rd_req,
    input  logic                             rd_grant,
    input  logic                             rd_return_valid,
    input  logic [depth_pkg::data_width-1:0] rd_return_data,
    output logic                             wr_valid,
    output depth_pkg::write_req_t            wr_req,
    input  logic                             wr_grant,
    output logic                             retire_pass,
    output logic                             retire_fail
);

    typedef enum logic [1:0] {s_idle, s_color, s_depth} state_t;

    state_t state;
    logic out_valid;
    logic release_valid;
    depth_pkg::fragment_t out_fragment;
    depth_pkg::fragment_t result;
    logic [depth_pkg::data_width-1:0] old_depth;

    depth_fetch #(.lane_depth(lane_depth)) i_fetch (
        .clock(clock),
        .reset(reset),
        .frag_valid(frag_valid),
        .frag(frag),
        .stall(stall),
        .rd_valid(rd_valid),
        .rd_req(rd_req),
        .rd_grant(rd_grant),
        .rd_return_valid(rd_return_valid),
        .rd_return_data(rd_return_data),
        .out_valid(out_valid),
        .out_fragment(out_fragment),
        .old_depth(old_depth),
        .release_valid(release_valid)
    );

    assign release_valid = retire_pass || retire_fail;
    assign wr_valid = (state != s_idle);

    // Colour beat keeps the top byte of the word untouched
    always_comb begin
        wr_req.addr = result.addr;
        wr_req.data = {8'h00, result.color};
        wr_req.byteenable = 4'b0111;
        if (state == s_depth) begin
            wr_req.addr = result.addr + depth_pkg::addr_width'(depth_pkg::depth_offset);
            wr_req.data = result.depth;
            wr_req.byteenable = 4'b1111;
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state <= s_idle;
            retire_pass <= 1'b0;
            retire_fail <= 1'b0;
        end else begin
            retire_pass <= 1'b0;
            retire_fail <= 1'b0;
            case (state)
                s_idle: begin
                    if (out_valid && out_fragment.depth < old_depth)
                        state <= s_color;
                    else if (out_valid)
                        retire_fail <= 1'b1;
                end
                s_color: begin
                    if (wr_grant)
                        state <= s_depth;
                end
                default: begin
                    if (wr_grant) begin
                        state <= s_idle;
                        retire_pass <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (out_valid)
            result <= out_fragment;
    end

    // The fetch holds the next result back until this one has retired
    assert property (@(posedge clock) disable iff (!reset) out_valid |-> state == s_idle);

endmodule

/* verilog/depth_fetch.sv */
`timescale 1ns/1ps

module depth_fetch #(
    parameter int lane_depth = 4
) (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             frag_valid,
    input  depth_pkg::fragment_t             frag,
    output logic                             stall,
    output logic                             rd_valid,
    output depth_pkg::read_req_t             rd_req,
    input  logic                             rd_grant,
    input  logic                             rd_return_valid,
    input  logic [depth_pkg::data_width-1:0] rd_return_data,
    output logic                             out_valid,
    output depth_pkg::fragment_t             out_fragment,
    output logic [depth_pkg::data_width-1:0] old_depth,
    input  logic                             release_valid
);

    localparam int ptr_width = (lane_depth > 1) ? $clog2(lane_depth) : 1;
    localparam logic [ptr_width-1:0] last = ptr_width'(lane_depth - 1);

    logic [depth_pkg::addr_width-1:0] sb_addr [lane_depth];
    logic [lane_depth-1:0] sb_valid;
    logic [ptr_width-1:0] alloc_ptr;
    logic [ptr_width-1:0] free_ptr;
    logic hazard;
    logic accept;
    logic busy;
    logic take;
    logic frag_full;
    logic frag_empty;
    logic depth_empty;
    depth_pkg::fragment_t queued;
    logic [depth_pkg::data_width-1:0] depth_head;
    logic [depth_pkg::data_width-1:0] depth_now;

    always_comb begin
        hazard = 1'b0;
        for (int i = 0; i < lane_depth; i++) begin
            if (sb_valid[i] && sb_addr[i] == frag.addr)
                hazard = 1'b1;
        end
    end

    // Scoreboard allocates in order, so a valid entry at alloc_ptr means full
    assign stall = sb_valid[alloc_ptr] || frag_full || hazard || (rd_valid && !rd_grant);
    assign accept = frag_valid && !stall;

    // Returned depths wait here while the lane is still writing back
    assign depth_now = depth_empty ? rd_return_data : depth_head;
    assign take = (!depth_empty || rd_return_valid) && (!busy || release_valid);

    request_fifo #(.payload_t(depth_pkg::fragment_t), .depth(lane_depth)) i_frag_fifo (
        .clock(clock),
        .reset(reset),
        .push(accept),
        .push_data(frag),
        .pop(take),
        .pop_data(queued),
        .full(frag_full),
        .empty(frag_empty)
    );

    request_fifo #(.payload_t(logic [depth_pkg::data_width-1:0]), .depth(lane_depth)) i_depth_fifo (
        .clock(clock),
        .reset(reset),
        .push(rd_return_valid && !(take && depth_empty)),
        .push_data(rd_return_data),
        .pop(take && !depth_empty),
        .pop_data(depth_head),
        .full(),
        .empty(depth_empty)
    );

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            sb_valid <= '0;
            alloc_ptr <= '0;
            free_ptr <= '0;
            rd_valid <= 1'b0;
            busy <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (accept) begin
                sb_valid[alloc_ptr] <= 1'b1;
                alloc_ptr <= (alloc_ptr == last) ? '0 : alloc_ptr + 1'b1;
            end
            if (release_valid) begin
                sb_valid[free_ptr] <= 1'b0;
                free_ptr <= (free_ptr == last) ? '0 : free_ptr + 1'b1;
            end
            if (accept)
                rd_valid <= 1'b1;
            else if (rd_grant)
                rd_valid <= 1'b0;
            if (take)
                busy <= 1'b1;
            else if (release_valid)
                busy <= 1'b0;
            out_valid <= take;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            sb_addr[alloc_ptr] <= frag.addr;
            rd_req.addr <= frag.addr + depth_pkg::addr_width'(depth_pkg::depth_offset);
        end
        if (take) begin
            out_fragment <= queued;
            old_depth <= depth_now;
        end
    end

    // Reads return in order, so each one belongs to a queued fragment
    assert property (@(posedge clock) disable iff (!reset) rd_return_valid |-> !frag_empty);

endmodule

/* verilog/fragment_dispatch.sv */
`timescale 1ns/1ps

module fragment_dispatch #(
    parameter int lane_count = 4
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  fragment_valid,
    input  depth_pkg::fragment_t  fragment,
    output logic                  fragment_stall,
    output logic [lane_count-1:0] lane_valid,
    output depth_pkg::fragment_t  lane_fragment,
    input  logic [lane_count-1:0] lane_stall
);

    localparam int lane_bits = $clog2(lane_count);
    typedef logic [lane_bits-1:0] lane_idx_t;

    logic ready;
    logic held_valid;
    logic drain;
    depth_pkg::fragment_t held;
    lane_idx_t held_lane;

    // Pixels interleave over the lanes just above the 8-byte offset
    assign held_lane = held.addr[depth_pkg::pixel_shift +: lane_bits];
    assign drain = held_valid && !lane_stall[held_lane];
    assign fragment_stall = !ready || (held_valid && !drain);
    assign lane_fragment = held;

    always_comb begin
        lane_valid = '0;
        lane_valid[held_lane] = held_valid;
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            ready <= 1'b0;
            held_valid <= 1'b0;
        end else begin
            ready <= 1'b1;
            if (fragment_valid && !fragment_stall)
                held_valid <= 1'b1;
            else if (drain)
                held_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (fragment_valid && !fragment_stall)
            held <= fragment;
    end

endmodule

/* verilog/request_fifo.sv */
`timescale 1ns/1ps

module request_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int depth = 4
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     full,
    output logic     empty
);

    localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;
    localparam logic [ptr_width-1:0] last = ptr_width'(depth - 1);

    payload_t storage [depth];
    logic [ptr_width-1:0] wr_ptr;
    logic [ptr_width-1:0] rd_ptr;
    logic [ptr_width:0] count;

    assign full = (count == (ptr_width + 1)'(depth));
    assign empty = (count == '0);
    assign pop_data = storage[rd_ptr];

    always_ff @(posedge clock) begin
        if (push)
            storage[wr_ptr] <= push_data;
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == last) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == last) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assert property (@(posedge clock) disable iff (!reset) push |-> !full);
    assert property (@(posedge clock) disable iff (!reset) pop |-> !empty);

endmodule

/* verilog/depth_pkg.sv */
package depth_pkg;

    localparam int addr_width = 26;
    localparam int data_width = 32;
    localparam int color_width = 24;

    // Each pixel takes 8 bytes, colour word first and depth word after it
    localparam int pixel_shift = 3;
    localparam int depth_offset = 4;

    typedef struct packed {
        logic [addr_width-1:0] addr;
        logic [color_width-1:0] color;
        logic [data_width-1:0] depth;
    } fragment_t;

    typedef struct packed {
        logic [addr_width-1:0] addr;
    } read_req_t;

    typedef struct packed {
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] data;
        logic [3:0] byteenable;
    } write_req_t;

    typedef struct packed {
        logic [addr_width-1:0] address;
        logic read;
        logic write;
        logic [3:0] byteenable;
        logic [data_width-1:0] writedata;
    } bus_t;

endpackage
